// File: gfx_pkg.sv
package gfx_pkg;

    // Q16.16 signed fixed point
    typedef logic signed [31:0] fixed;

    localparam int FRAC_BITS = 16;

    // Perspective constants
    localparam fixed FOCAL_LENGTH = 32'sh0000_8000;
    localparam fixed NEAR_Z       = 32'sh0000_4000;

    // Buffering and counters
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;
    localparam int CULL_CNT_W = 16;

    // One quotient bit per step
    localparam int DIV_STEPS = 32;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

    typedef logic [23:0] color_t;

    typedef struct packed {
        fixed x;
        fixed y;
        fixed z;
    } vec3_t;

    typedef struct packed {
        vec3_t  position;
        color_t color;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Unit moved through FIFO and cull stage
    typedef struct packed {
        triangle_t triangle;
        logic      tag;
    } tri_item_t;

    typedef enum logic [2:0] {
        IDLE,
        DIV_V0,
        DIV_V1,
        DIV_V2,
        PROJ,
        OUT
    } proj_state_t;

    function automatic fixed fx_mul(fixed a, fixed b);
        logic signed [63:0] prod;
        prod = a * b;
        return fixed'(prod >>> FRAC_BITS);
    endfunction

    // p' = f * p * (1/z)
    function automatic fixed fx_project(fixed f, fixed p, fixed rz);
        return fx_mul(f, fx_mul(p, rz));
    endfunction

endpackage

// File: triangle_fifo.sv
`timescale 1ns/1ns

module triangle_fifo (
    input  logic               clk,
    input  logic               rstn,
    input  gfx_pkg::tri_item_t wr_item,
    input  logic               wr_valid,
    output logic               wr_ready,
    output gfx_pkg::tri_item_t rd_item,
    output logic               rd_valid,
    input  logic               rd_ready
);
    import gfx_pkg::*;

    tri_item_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_wr;
    logic                  do_rd;

    assign wr_ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign rd_valid = (count != '0);
    assign rd_item  = mem[rd_ptr];
    assign do_wr    = wr_valid && wr_ready;
    assign do_rd    = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_item;
    end

    // Pointers wrap naturally since depth is a power of two
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        count <= FIFO_CNT_W'(FIFO_DEPTH));

endmodule

// File: near_cull.sv
`timescale 1ns/1ns

module near_cull (
    input  logic                          clk,
    input  logic                          rstn,
    input  gfx_pkg::tri_item_t            s_item,
    input  logic                          s_valid,
    output logic                          s_ready,
    output gfx_pkg::tri_item_t            m_item,
    output logic                          m_valid,
    input  logic                          m_ready,
    output logic [gfx_pkg::CULL_CNT_W-1:0] culled_count
);
    import gfx_pkg::*;

    logic accept;
    logic too_near;

    // Any vertex in front of the near limit drops the whole triangle
    assign too_near = (s_item.triangle.v0.position.z < NEAR_Z) ||
                      (s_item.triangle.v1.position.z < NEAR_Z) ||
                      (s_item.triangle.v2.position.z < NEAR_Z);

    assign s_ready = !m_valid || m_ready;
    assign accept  = s_valid && s_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            m_valid      <= 1'b0;
            culled_count <= '0;
        end else begin
            // Register is empty or drained whenever s_ready is high
            if (s_ready)
                m_valid <= accept && !too_near;
            if (accept && too_near)
                culled_count <= culled_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !too_near)
            m_item <= s_item;
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (!rstn)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_item)));

endmodule

// File: fixed_reciprocal_divider.sv
`timescale 1ns/1ns

module fixed_reciprocal_divider (
    input  logic          clk,
    input  logic          rstn,
    input  gfx_pkg::fixed divisor,
    input  logic          div_valid,
    output logic          div_ready,
    output gfx_pkg::fixed recip,
    output logic          recip_valid
);
    import gfx_pkg::*;

    logic                 busy;
    logic [DIV_CNT_W-1:0] step_cnt;
    logic                 accept;
    logic                 last_step;
    logic [32:0]          dvsr;
    logic [32:0]          rem;
    logic [32:0]          rem_shift;
    logic [32:0]          rem_diff;
    logic [31:0]          quot;

    assign div_ready = !busy;
    assign accept    = div_valid && div_ready;
    assign last_step = (step_cnt == DIV_CNT_W'(DIV_STEPS));

    // Borrow of the trial subtraction shows up in the top bit
    always_comb begin
        rem_shift = {rem[31:0], 1'b0};
        rem_diff  = rem_shift - dvsr;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy        <= 1'b0;
            step_cnt    <= '0;
            recip_valid <= 1'b0;
        end else begin
            recip_valid <= 1'b0;
            if (accept) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                if (last_step) begin
                    busy        <= 1'b0;
                    recip_valid <= 1'b1;
                end else begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end
        end
    end

    // Leading one of the 2^32 dividend is preloaded into the remainder
    always_ff @(posedge clk) begin
        if (accept) begin
            rem  <= 33'd1;
            quot <= '0;
            dvsr <= {1'b0, divisor};
        end else if (busy && !last_step) begin
            if (!rem_diff[32]) begin
                rem  <= rem_diff;
                quot <= {quot[30:0], 1'b1};
            end else begin
                rem  <= rem_shift;
                quot <= {quot[30:0], 1'b0};
            end
        end
        if (busy && last_step)
            recip <= fixed'(quot);
    end

    a_no_req_busy: assert property (@(posedge clk) disable iff (!rstn)
        busy |-> !div_valid);

endmodule

// File: projection.sv
`timescale 1ns/1ns

module projection (
    input  logic               clk,
    input  logic               rstn,
    input  gfx_pkg::tri_item_t s_item,
    input  logic               s_valid,
    output logic               s_ready,
    output gfx_pkg::tri_item_t m_item,
    output logic               m_valid,
    input  logic               m_ready
);
    import gfx_pkg::*;

    proj_state_t state;
    proj_state_t next_state;
    tri_item_t   item_q;
    tri_item_t   out_q;
    fixed        rec_z0;
    fixed        rec_z1;
    fixed        rec_z2;
    fixed        divisor;
    fixed        recip;
    logic        div_valid;
    logic        div_ready;
    logic        recip_valid;
    logic        req_sent;
    logic        in_div;

    function automatic vertex_t proj_vertex(vertex_t v, fixed rz);
        vertex_t r;
        r.position.x = fx_project(FOCAL_LENGTH, v.position.x, rz);
        r.position.y = fx_project(FOCAL_LENGTH, v.position.y, rz);
        r.position.z = rz;
        r.color      = v.color;
        return r;
    endfunction

    fixed_reciprocal_divider u_divider (
        .clk         (clk),
        .rstn        (rstn),
        .divisor     (divisor),
        .div_valid   (div_valid),
        .div_ready   (div_ready),
        .recip       (recip),
        .recip_valid (recip_valid)
    );

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (s_valid) next_state = DIV_V0;
            DIV_V0:  if (recip_valid) next_state = DIV_V1;
            DIV_V1:  if (recip_valid) next_state = DIV_V2;
            DIV_V2:  if (recip_valid) next_state = PROJ;
            PROJ:    next_state = OUT;
            OUT:     if (m_valid && m_ready) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            state <= IDLE;
        else
            state <= next_state;
    end

    assign s_ready = (state == IDLE);
    assign in_div  = (state == DIV_V0) || (state == DIV_V1) || (state == DIV_V2);

    // One request per vertex, issued on the first cycle of its state
    assign div_valid = in_div && !req_sent;

    always_comb begin
        case (state)
            DIV_V1:  divisor = item_q.triangle.v1.position.z;
            DIV_V2:  divisor = item_q.triangle.v2.position.z;
            default: divisor = item_q.triangle.v0.position.z;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            req_sent <= 1'b0;
        else if (recip_valid)
            req_sent <= 1'b0;
        else if (div_valid && div_ready)
            req_sent <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (s_valid && s_ready)
            item_q <= s_item;
        if (recip_valid) begin
            case (state)
                DIV_V0:  rec_z0 <= recip;
                DIV_V1:  rec_z1 <= recip;
                DIV_V2:  rec_z2 <= recip;
                default: rec_z0 <= rec_z0;
            endcase
        end
        if (state == PROJ) begin
            out_q.triangle.v0 <= proj_vertex(item_q.triangle.v0, rec_z0);
            out_q.triangle.v1 <= proj_vertex(item_q.triangle.v1, rec_z1);
            out_q.triangle.v2 <= proj_vertex(item_q.triangle.v2, rec_z2);
            out_q.tag         <= item_q.tag;
        end
    end

    // Result held until the consumer takes it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            m_valid <= 1'b0;
        else if (state == PROJ)
            m_valid <= 1'b1;
        else if (m_valid && m_ready)
            m_valid <= 1'b0;
    end

    assign m_item = out_q;

    a_valid_in_out: assert property (@(posedge clk) disable iff (!rstn)
        m_valid |-> (state == OUT));

endmodule

// File: projection_pipeline.sv
`timescale 1ns/1ns

module projection_pipeline (
    input  logic                          clk,
    input  logic                          rstn,
    input  gfx_pkg::tri_item_t            in_data,
    input  logic                          in_valid,
    output logic                          in_ready,
    output gfx_pkg::tri_item_t            out_data,
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [gfx_pkg::CULL_CNT_W-1:0] culled_count
);
    import gfx_pkg::*;

    tri_item_t fifo_item;
    logic      fifo_valid;
    logic      fifo_ready;
    tri_item_t cull_item;
    logic      cull_valid;
    logic      cull_ready;

    // Input buffer absorbs bursts while projection is busy
    triangle_fifo u_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .wr_item  (in_data),
        .wr_valid (in_valid),
        .wr_ready (in_ready),
        .rd_item  (fifo_item),
        .rd_valid (fifo_valid),
        .rd_ready (fifo_ready)
    );

    near_cull u_cull (
        .clk          (clk),
        .rstn         (rstn),
        .s_item       (fifo_item),
        .s_valid      (fifo_valid),
        .s_ready      (fifo_ready),
        .m_item       (cull_item),
        .m_valid      (cull_valid),
        .m_ready      (cull_ready),
        .culled_count (culled_count)
    );

    projection u_proj (
        .clk     (clk),
        .rstn    (rstn),
        .s_item  (cull_item),
        .s_valid (cull_valid),
        .s_ready (cull_ready),
        .m_item  (out_data),
        .m_valid (out_valid),
        .m_ready (out_ready)
    );

endmodule

// File: clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
    output logic clk,
    output logic rstn
);
    localparam int HALF_PERIOD  = 4;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release lands just after an edge, away from the flops' sampling point
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

// File: tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
    input  logic                           clk,
    input  logic                           rstn,
    input  gfx_pkg::tri_item_t             in_data,
    input  logic                           in_valid,
    input  logic                           in_ready,
    input  gfx_pkg::tri_item_t             out_data,
    input  logic                           out_valid,
    input  logic                           out_ready,
    input  logic [gfx_pkg::CULL_CNT_W-1:0] culled_count,
    input  logic                           end_req,
    output logic                           end_done,
    output logic                           settled,
    output int                             error_count,
    output int                             check_count
);
    import gfx_pkg::*;

    tri_item_t             exp_q[$];
    logic [CULL_CNT_W-1:0] exp_culled;
    int                    culled_total;
    int                    in_count;
    int                    out_count;
    logic                  reset_checked;
    logic                  prev_stall;
    tri_item_t             prev_item;

    // floor(2^32 / z) for the positive z that survives culling
    function automatic fixed ref_recip(fixed z);
        logic [63:0] q;
        q = 64'h1_0000_0000 / {32'h0, z};
        return fixed'(q[31:0]);
    endfunction

    function automatic vertex_t ref_vertex(vertex_t v);
        vertex_t r;
        fixed    rz;
        rz           = ref_recip(v.position.z);
        r.position.x = fx_project(FOCAL_LENGTH, v.position.x, rz);
        r.position.y = fx_project(FOCAL_LENGTH, v.position.y, rz);
        r.position.z = rz;
        r.color      = v.color;
        return r;
    endfunction

    function automatic logic too_near(triangle_t t);
        return (t.v0.position.z < NEAR_Z) || (t.v1.position.z < NEAR_Z) ||
               (t.v2.position.z < NEAR_Z);
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_vertex(string name, vertex_t e, vertex_t a);
        check_value({"out_data.", name, ".x"}, e.position.x, a.position.x);
        check_value({"out_data.", name, ".y"}, e.position.y, a.position.y);
        check_value({"out_data.", name, ".z"}, e.position.z, a.position.z);
        check_value({"out_data.", name, ".color"}, 32'(e.color), 32'(a.color));
    endtask

    task automatic accept_input();
        tri_item_t e;
        in_count++;
        if (too_near(in_data.triangle)) begin
            exp_culled = exp_culled + 1'b1;
            culled_total++;
        end else begin
            e.triangle.v0 = ref_vertex(in_data.triangle.v0);
            e.triangle.v1 = ref_vertex(in_data.triangle.v1);
            e.triangle.v2 = ref_vertex(in_data.triangle.v2);
            e.tag         = in_data.tag;
            exp_q.push_back(e);
        end
    endtask

    task automatic take_output();
        tri_item_t e;
        out_count++;
        if (exp_q.size() == 0) begin
            error_count++;
            $display("Output triangle %0d arrived with no triangle expected at %0t",
                     out_count, $time);
        end else begin
            e = exp_q.pop_front();
            check_vertex("v0", e.triangle.v0, out_data.triangle.v0);
            check_vertex("v1", e.triangle.v1, out_data.triangle.v1);
            check_vertex("v2", e.triangle.v2, out_data.triangle.v2);
            check_value("out_data.tag", 32'(e.tag), 32'(out_data.tag));
        end
    endtask

    // Output must hold while the consumer stalls
    task automatic check_stall();
        check_count++;
        if (!out_valid) begin
            error_count++;
            $display("out_valid dropped while out_ready was low at %0t", $time);
        end else if (out_data !== prev_item) begin
            error_count++;
            $display("ERROR out_data expected %h actual %h at %0t", prev_item, out_data, $time);
        end
    endtask

    task automatic final_check();
        check_value("culled_count", 32'(exp_culled), 32'(culled_count));
        check_count++;
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected triangles never left the pipeline", exp_q.size());
        end
        check_count++;
        if (out_count != in_count - culled_total) begin
            error_count++;
            $display("Got %0d output triangles for %0d inputs with %0d culled",
                     out_count, in_count, culled_total);
        end
    endtask

    // Sampled mid-cycle, where inputs and outputs are both settled
    always @(negedge clk) begin
        if (!rstn) begin
            exp_q.delete();
            exp_culled    = '0;
            culled_total  = 0;
            in_count      = 0;
            out_count     = 0;
            error_count   = 0;
            check_count   = 0;
            reset_checked = 1'b0;
            prev_stall    = 1'b0;
            end_done      = 1'b0;
        end else begin
            if (!reset_checked) begin
                check_value("out_valid", 32'h0, 32'(out_valid));
                check_value("in_ready", 32'h1, 32'(in_ready));
                check_value("culled_count", 32'h0, 32'(culled_count));
                reset_checked = 1'b1;
            end
            if (prev_stall)
                check_stall();
            if (in_valid && in_ready)
                accept_input();
            if (out_valid && out_ready)
                take_output();
            prev_stall = out_valid && !out_ready;
            prev_item  = out_data;
            if (end_req && !end_done) begin
                final_check();
                end_done = 1'b1;
            end
        end
        settled = (exp_q.size() == 0) && (culled_count == exp_culled);
    end

endmodule

// File: tb_top.sv
`timescale 1ns/1ns

module tb_top;
    import gfx_pkg::*;

    localparam int NUM_TRIS       = 200;
    localparam int CYCLES_PER_TRI = 150;
    localparam int CLK_PERIOD     = 8;
    localparam int DRAIN_CYCLES   = (FIFO_DEPTH + 2) * CYCLES_PER_TRI;
    localparam int TIMEOUT_NS     = NUM_TRIS * CYCLES_PER_TRI * CLK_PERIOD;

    logic                  clk;
    logic                  rstn;
    tri_item_t             in_data;
    logic                  in_valid;
    logic                  in_ready;
    tri_item_t             out_data;
    logic                  out_valid;
    logic                  out_ready;
    logic [CULL_CNT_W-1:0] culled_count;
    logic                  end_req;
    logic                  end_done;
    logic                  settled;
    int                    error_count;
    int                    check_count;
    integer                seed = 62;

    clk_gen u_clk_gen (
        .clk  (clk),
        .rstn (rstn)
    );

    projection_pipeline dut (
        .clk          (clk),
        .rstn         (rstn),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .culled_count (culled_count)
    );

    tb_checker chk (
        .clk          (clk),
        .rstn         (rstn),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .culled_count (culled_count),
        .end_req      (end_req),
        .end_done     (end_done),
        .settled      (settled),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    // x and y in +-4.0, z in [0, 8.0) so about 1 in 32 vertices is too near
    task automatic random_vertex(output vertex_t v);
        v.position.x = $random(seed) % 32'sd262144;
        v.position.y = $random(seed) % 32'sd262144;
        v.position.z = $random(seed) & 32'sh0007_ffff;
        v.color      = 24'($random(seed));
    endtask

    // Holds the item until the FIFO takes it and returns just after that edge
    task automatic send_triangle();
        tri_item_t item;
        logic      taken;
        random_vertex(item.triangle.v0);
        random_vertex(item.triangle.v1);
        random_vertex(item.triangle.v2);
        item.tag = 1'($random(seed));
        in_data  = item;
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    initial begin
        int gap;
        int waited;
        in_data  = '0;
        in_valid = 1'b0;
        end_req  = 1'b0;
        @(posedge rstn);
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_TRIS; i++) begin
            send_triangle();
            gap = {$random(seed)} % 4;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        // Let the triangles still in flight drain out
        waited = 0;
        while (!settled && waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        end_req = 1'b1;
        wait (end_done);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Back-pressure on about 30% of cycles
    initial begin
        out_ready = 1'b0;
        @(posedge rstn);
        forever begin
            @(posedge clk);
            #1;
            out_ready = ({$random(seed)} % 10) >= 3;
        end
    end

    initial begin
        #TIMEOUT_NS;
        $display("Timeout: the pipeline did not drain within %0d ns", TIMEOUT_NS);
        $display("checks %0d, errors %0d", check_count, error_count);
        $display("sim failed");
        $finish;
    end

endmodule

// File: tb.f
gfx_pkg.sv
triangle_fifo.sv
near_cull.sv
fixed_reciprocal_divider.sv
projection.sv
projection_pipeline.sv
clk_gen.sv
tb_checker.sv
tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the projection pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f tb.f --top-module tb_top -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
